//--- mem_subsys.f
mem_pkg.sv
lane_translator.sv
word_sram.sv
mem_arbiter.sv
fetch_port.sv
data_port.sv
mem_subsys.sv
tb_mem_subsys.sv

//--- Bender.yml
package:
  name: mem_subsys

sources:
  - mem_pkg.sv
  - lane_translator.sv
  - word_sram.sv
  - mem_arbiter.sv
  - fetch_port.sv
  - data_port.sv
  - mem_subsys.sv
  - target: simulation
    files:
      - tb_mem_subsys.sv

//--- tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys import mem_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 20;

    logic               clk = 1'b0;
    logic               rst;
    logic               fetch_req;
    logic [WADDR_W-1:0] fetch_addr;
    logic               fetch_busy;
    logic               fetch_done;
    sram_word_u         fetch_instr;
    logic               data_req;
    logic [OP_W-1:0]    data_op;
    logic [BADDR_W-1:0] data_addr;
    logic [31:0]        data_wdata;
    logic               data_busy;
    logic               data_done;
    sram_word_u         data_rdata;

    // Reference memory with index 0 as the most significant byte
    logic [7:0]      model_mem [SRAM_DEPTH][4];
    logic [31:0]     rng_state;
    logic [OP_W-1:0] load_ops [5];
    logic [OP_W-1:0] all_ops [8];
    int              load_errors;
    int              fetch_errors;
    int              flag_errors;
    int              timeouts;

    always #5 clk = ~clk;

    mem_subsys i_mem_subsys (
        .clk         (clk),
        .rst         (rst),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_busy  (fetch_busy),
        .fetch_done  (fetch_done),
        .fetch_instr (fetch_instr),
        .data_req    (data_req),
        .data_op     (data_op),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_busy   (data_busy),
        .data_done   (data_done),
        .data_rdata  (data_rdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Random source and reference model
    ////////////////////////////////////////////////////////////////////////////

    function logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic sram_word_u model_word(int w);
        sram_word_u r;
        r.word = {model_mem[w][0], model_mem[w][1], model_mem[w][2], model_mem[w][3]};
        return r;
    endfunction

    function automatic void model_store(logic [OP_W-1:0] op, logic [BADDR_W-1:0] addr,
                                        logic [31:0] wdata);
        int         w;
        logic [1:0] off;
        w = addr[BADDR_W-1:2];
        off = addr[1:0];
        case (op)
            op_sw:
            begin
                model_mem[w][0] = wdata[31:24];
                model_mem[w][1] = wdata[23:16];
                model_mem[w][2] = wdata[15:8];
                model_mem[w][3] = wdata[7:0];
            end
            op_sh:
            begin
                // Odd offsets write nothing
                if (off == 2'd0 || off == 2'd2)
                begin
                    model_mem[w][off] = wdata[15:8];
                    model_mem[w][off + 1] = wdata[7:0];
                end
            end
            op_sb: model_mem[w][off] = wdata[7:0];
            default: ;
        endcase
    endfunction

    function automatic sram_word_u model_load(logic [OP_W-1:0] op, logic [BADDR_W-1:0] addr);
        int         w;
        logic [1:0] off;
        logic [7:0] b;
        logic [15:0] h;
        sram_word_u r;
        w = addr[BADDR_W-1:2];
        off = addr[1:0];
        b = model_mem[w][off];
        h = {model_mem[w][{off[1], 1'b0}], model_mem[w][{off[1], 1'b1}]};
        case (op)
            op_lw: r = model_word(w);
            op_lh: r.word = off[0] ? 32'h0 : {{16{h[15]}}, h};
            op_lhu: r.word = off[0] ? 32'h0 : {16'h0, h};
            op_lb: r.word = {{24{b[7]}}, b};
            op_lbu: r.word = {24'h0, b};
            default: r.word = 32'h0;
        endcase
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_load(input sram_word_u got, input sram_word_u exp, input string what);
        if (got.word !== exp.word)
        begin
            load_errors++;
            $display("[ERROR] %0t: %s got %08h expected %08h", $time, what, got.word, exp.word);
        end
    endtask

    task automatic check_fetch(input sram_word_u got, input sram_word_u exp, input string what);
        if (got.word !== exp.word)
        begin
            fetch_errors++;
            $display("[ERROR] %0t: %s got %08h expected %08h", $time, what, got.word, exp.word);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            flag_errors++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic data_access(input logic [OP_W-1:0] op, input logic [BADDR_W-1:0] addr,
                               input logic [31:0] wdata, output sram_word_u got);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        got.word = 'x;
        @(posedge clk);
        data_req   <= 1'b1;
        data_op    <= op;
        data_addr  <= addr;
        data_wdata <= wdata;
        @(posedge clk);
        data_req <= 1'b0;
        while (!seen && cycles < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            cycles++;
            seen = data_done;
        end
        if (seen)
            got = data_rdata;
        else
        begin
            timeouts++;
            $display("Timeout: data port never finished op %02h at address %03h", op, addr);
        end
    endtask

    task automatic fetch_word(input logic [WADDR_W-1:0] fa, output sram_word_u got);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        got.word = 'x;
        @(posedge clk);
        fetch_req  <= 1'b1;
        fetch_addr <= fa;
        @(posedge clk);
        fetch_req <= 1'b0;
        while (!seen && cycles < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            cycles++;
            seen = fetch_done;
        end
        if (seen)
            got = fetch_instr;
        else
        begin
            timeouts++;
            $display("Timeout: fetch port never returned the word at %02h", fa);
        end
    endtask

    task automatic store_and_track(input logic [OP_W-1:0] op, input logic [BADDR_W-1:0] addr,
                                   input logic [31:0] wdata);
        sram_word_u got;
        sram_word_u zero;
        zero.word = 32'h0;
        data_access(op, addr, wdata, got);
        check_load(got, zero, "store read data");
        model_store(op, addr, wdata);
    endtask

    task automatic compare_word(input int w);
        sram_word_u got;
        data_access(op_lw, BADDR_W'(w << 2), 32'h0, got);
        check_load(got, model_word(w), "word readback");
    endtask

    // Both ports strobed in the same cycle
    task automatic run_pair(input logic [WADDR_W-1:0] fa, input logic [OP_W-1:0] op,
                            input logic [BADDR_W-1:0] addr, input logic [31:0] wdata,
                            output sram_word_u f_got, output sram_word_u d_got);
        int cycles;
        bit f_seen;
        bit d_seen;
        cycles = 0;
        f_seen = 1'b0;
        d_seen = 1'b0;
        f_got.word = 'x;
        d_got.word = 'x;
        @(posedge clk);
        fetch_req  <= 1'b1;
        fetch_addr <= fa;
        data_req   <= 1'b1;
        data_op    <= op;
        data_addr  <= addr;
        data_wdata <= wdata;
        @(posedge clk);
        fetch_req <= 1'b0;
        data_req  <= 1'b0;
        while (!(f_seen && d_seen) && cycles < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            cycles++;
            if (fetch_done)
            begin
                f_seen = 1'b1;
                f_got = fetch_instr;
            end
            if (data_done)
            begin
                d_seen = 1'b1;
                d_got = data_rdata;
            end
        end
        if (!(f_seen && d_seen))
        begin
            timeouts++;
            $display("Timeout: paired request lost, fetch done %b, data done %b", f_seen, d_seen);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        sram_word_u       got;
        sram_word_u       f_got;
        sram_word_u       exp;
        sram_word_u       zero;
        logic [7:0]       wb;
        logic [WADDR_W-1:0] fa;
        logic [WADDR_W-1:0] dw;
        logic [1:0]       off;
        logic [OP_W-1:0]  op;
        logic [31:0]      r;

        rng_state = 32'h589a;
        load_errors = 0;
        fetch_errors = 0;
        flag_errors = 0;
        timeouts = 0;
        zero.word = 32'h0;
        load_ops = '{op_lb, op_lbu, op_lh, op_lhu, op_lw};
        all_ops = '{op_lb, op_lbu, op_lh, op_lhu, op_lw, op_sb, op_sh, op_sw};
        rst = 1'b1;
        fetch_req = 1'b0;
        fetch_addr = '0;
        data_req = 1'b0;
        data_op = '0;
        data_addr = '0;
        data_wdata = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        check_flag(fetch_busy, 1'b0, "fetch_busy after reset");
        check_flag(data_busy, 1'b0, "data_busy after reset");
        check_flag(fetch_done, 1'b0, "fetch_done after reset");
        check_flag(data_done, 1'b0, "data_done after reset");

        // Fill every word through the data port
        for (int w = 0; w < SRAM_DEPTH; w++)
        begin
            wb = w[7:0];
            store_and_track(op_sw, BADDR_W'(w << 2),
                            {wb ^ 8'ha5, wb + 8'h3c, ~wb, {wb[3:0], wb[7:4]}});
        end

        // Aligned stores of each size
        repeat (60)
        begin
            r = next_random();
            dw = r[7:0];
            off = r[9:8];
            case (r[11:10] % 3)
                0: op = op_sw;
                1: op = op_sh;
                default: op = op_sb;
            endcase
            if (op == op_sw)
                off = 2'd0;
            else if (op == op_sh)
                off[0] = 1'b0;
            store_and_track(op, {dw, off}, next_random());
            compare_word(dw);
        end

        // Every load kind at every offset
        repeat (16)
        begin
            dw = WADDR_W'(next_random());
            for (int o = 0; o < 4; o++)
            begin
                for (int k = 0; k < 5; k++)
                begin
                    data_access(load_ops[k], {dw, o[1:0]}, 32'h0, got);
                    check_load(got, model_load(load_ops[k], {dw, o[1:0]}), "load");
                end
            end
        end

        // Misaligned halves
        repeat (8)
        begin
            dw = WADDR_W'(next_random());
            store_and_track(op_sh, {dw, 2'd1}, next_random());
            store_and_track(op_sh, {dw, 2'd3}, next_random());
            compare_word(dw);
            data_access(op_lh, {dw, 2'd1}, 32'h0, got);
            check_load(got, zero, "misaligned lh");
            data_access(op_lhu, {dw, 2'd3}, 32'h0, got);
            check_load(got, zero, "misaligned lhu");
        end

        ////////////////////////////////////////////////////////////////////////
        // Contention between the ports
        ////////////////////////////////////////////////////////////////////////

        repeat (30)
        begin
            r = next_random();
            fa = r[7:0];
            dw = r[15:8];
            if (dw == fa)
                dw = fa + 8'd1;
            off = r[17:16];
            op = all_ops[r[20:18]];
            if (op == op_sw || op == op_lw)
                off = 2'd0;
            // A lone fetch first hands the next tie to the data port
            if (r[21])
            begin
                fetch_word(fa, f_got);
                check_fetch(f_got, model_word(fa), "single fetch");
            end
            exp = model_load(op, {dw, off});
            if (op == op_sb || op == op_sh || op == op_sw)
                exp = zero;
            r = next_random();
            run_pair(fa, op, {dw, off}, r, f_got, got);
            check_fetch(f_got, model_word(fa), "paired fetch");
            check_load(got, exp, "paired data access");
            model_store(op, {dw, off}, r);
            compare_word(dw);
        end

        $display("Errors: load %0d, fetch %0d, flag %0d, timeouts %0d",
                 load_errors, fetch_errors, flag_errors, timeouts);
        if (load_errors + fetch_errors + flag_errors + timeouts == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys import mem_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_req,
    input  logic [WADDR_W-1:0] fetch_addr,
    output logic               fetch_busy,
    output logic               fetch_done,
    output sram_word_u         fetch_instr,
    input  logic               data_req,
    input  logic [OP_W-1:0]    data_op,
    input  logic [BADDR_W-1:0] data_addr,
    input  logic [31:0]        data_wdata,
    output logic               data_busy,
    output logic               data_done,
    output sram_word_u         data_rdata
);

    logic               f_req;
    logic [WADDR_W-1:0] f_addr;
    logic               f_gnt;
    logic               d_req;
    logic [WADDR_W-1:0] d_addr;
    logic               d_we;
    logic [3:0]         d_be;
    sram_word_u         d_wdata;
    logic               d_gnt;

    // SRAM side
    logic               sram_en;
    logic               sram_we;
    logic [3:0]         sram_be;
    logic [WADDR_W-1:0] sram_addr;
    sram_word_u         sram_wdata;
    sram_word_u         sram_rdata;

    fetch_port i_fetch_port (
        .clk         (clk),
        .rst         (rst),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_busy  (fetch_busy),
        .fetch_done  (fetch_done),
        .fetch_instr (fetch_instr),
        .arb_req     (f_req),
        .arb_addr    (f_addr),
        .arb_gnt     (f_gnt),
        .sram_rdata  (sram_rdata)
    );

    data_port i_data_port (
        .clk        (clk),
        .rst        (rst),
        .data_req   (data_req),
        .data_op    (data_op),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_busy  (data_busy),
        .data_done  (data_done),
        .data_rdata (data_rdata),
        .arb_req    (d_req),
        .arb_addr   (d_addr),
        .arb_we     (d_we),
        .arb_be     (d_be),
        .arb_wdata  (d_wdata),
        .arb_gnt    (d_gnt),
        .sram_rdata (sram_rdata)
    );

    mem_arbiter i_mem_arbiter (
        .clk     (clk),
        .rst     (rst),
        .f_req   (f_req),
        .f_addr  (f_addr),
        .f_gnt   (f_gnt),
        .d_req   (d_req),
        .d_addr  (d_addr),
        .d_we    (d_we),
        .d_be    (d_be),
        .d_wdata (d_wdata),
        .d_gnt   (d_gnt),
        .en      (sram_en),
        .we      (sram_we),
        .be      (sram_be),
        .waddr   (sram_addr),
        .wdata   (sram_wdata)
    );

    word_sram i_word_sram (
        .clk   (clk),
        .rst   (rst),
        .en    (sram_en),
        .we    (sram_we),
        .be    (sram_be),
        .waddr (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

endmodule

//--- data_port.sv
`timescale 1ns/1ps

module data_port import mem_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               data_req,
    input  logic [OP_W-1:0]    data_op,
    input  logic [BADDR_W-1:0] data_addr,
    input  logic [31:0]        data_wdata,
    output logic               data_busy,
    output logic               data_done,
    output sram_word_u         data_rdata,
    output logic               arb_req,
    output logic [WADDR_W-1:0] arb_addr,
    output logic               arb_we,
    output logic [3:0]         arb_be,
    output sram_word_u         arb_wdata,
    input  logic               arb_gnt,
    input  sram_word_u         sram_rdata
);

    logic [OP_W-1:0]    op_q;
    logic [BADDR_W-1:0] addr_q;
    logic [31:0]        wdata_q;
    logic [31:0]        rd_fmt;
    logic               pending;
    logic               waiting;

    assign arb_req   = pending;
    assign data_busy = pending || waiting;
    assign arb_addr  = addr_q[BADDR_W-1:2];
    assign arb_we    = (op_q == op_sb) || (op_q == op_sh) || (op_q == op_sw);

    // Same translator serves the outgoing lanes and the returning word
    lane_translator i_lane_translator (
        .op         (op_q),
        .boff       (addr_q[1:0]),
        .wdata      (wdata_q),
        .sram_wdata (arb_wdata),
        .be         (arb_be),
        .sram_rdata (sram_rdata),
        .rdata      (rd_fmt)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pending   <= 1'b0;
            waiting   <= 1'b0;
            data_done <= 1'b0;
        end
        else
        begin
            data_done <= 1'b0;
            if (data_req)
                pending <= 1'b1;
            if (pending && arb_gnt)
            begin
                pending <= 1'b0;
                waiting <= 1'b1;
            end
            if (waiting)
            begin
                waiting   <= 1'b0;
                data_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (data_req)
        begin
            op_q    <= data_op;
            addr_q  <= data_addr;
            wdata_q <= data_wdata;
        end
        // Stores format to zero
        if (waiting)
            data_rdata.word <= rd_fmt;
    end

    a_no_req_busy: assert property (@(posedge clk) disable iff (rst) data_req |-> !data_busy);

endmodule

//--- fetch_port.sv
`timescale 1ns/1ps

module fetch_port import mem_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_req,
    input  logic [WADDR_W-1:0] fetch_addr,
    output logic               fetch_busy,
    output logic               fetch_done,
    output sram_word_u         fetch_instr,
    output logic               arb_req,
    output logic [WADDR_W-1:0] arb_addr,
    input  logic               arb_gnt,
    input  sram_word_u         sram_rdata
);

    logic pending;
    logic waiting;

    // Request level drops as soon as the grant is taken
    assign arb_req    = pending;
    assign fetch_busy = pending || waiting;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pending    <= 1'b0;
            waiting    <= 1'b0;
            fetch_done <= 1'b0;
        end
        else
        begin
            fetch_done <= 1'b0;
            if (fetch_req)
                pending <= 1'b1;
            if (pending && arb_gnt)
            begin
                pending <= 1'b0;
                waiting <= 1'b1;
            end
            if (waiting)
            begin
                waiting    <= 1'b0;
                fetch_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fetch_req)
            arb_addr <= fetch_addr;
        if (waiting)
            fetch_instr <= sram_rdata;
    end

    a_no_req_busy: assert property (@(posedge clk) disable iff (rst) fetch_req |-> !fetch_busy);

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import mem_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               f_req,
    input  logic [WADDR_W-1:0] f_addr,
    output logic               f_gnt,
    input  logic               d_req,
    input  logic [WADDR_W-1:0] d_addr,
    input  logic               d_we,
    input  logic [3:0]         d_be,
    input  sram_word_u         d_wdata,
    output logic               d_gnt,
    output logic               en,
    output logic               we,
    output logic [3:0]         be,
    output logic [WADDR_W-1:0] waddr,
    output sram_word_u         wdata
);

    // High when the data port took the last grant
    logic last_d;

    // Tie goes to whoever lost last time
    assign f_gnt = f_req && (!d_req || last_d);
    assign d_gnt = d_req && !f_gnt;

    always_ff @(posedge clk)
    begin
        if (rst)
            last_d <= 1'b1;
        else if (f_gnt)
            last_d <= 1'b0;
        else if (d_gnt)
            last_d <= 1'b1;
    end

    // Fetch never writes
    assign en    = f_gnt || d_gnt;
    assign we    = d_gnt && d_we;
    assign be    = (d_gnt && d_we) ? d_be : 4'b0000;
    assign waddr = d_gnt ? d_addr : f_addr;
    assign wdata = d_wdata;

    // A loser must win on the following cycle
    a_f_no_starve: assert property (@(posedge clk) disable iff (rst)
        f_req && !f_gnt |=> f_gnt);
    a_d_no_starve: assert property (@(posedge clk) disable iff (rst)
        d_req && !d_gnt |=> d_gnt);

endmodule

//--- word_sram.sv
`timescale 1ns/1ps

module word_sram import mem_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               en,
    input  logic               we,
    input  logic [3:0]         be,
    input  logic [WADDR_W-1:0] waddr,
    input  sram_word_u         wdata,
    output sram_word_u         rdata
);

    sram_word_u mem [SRAM_DEPTH];

    always_ff @(posedge clk)
    begin
        if (en && we)
        begin
            for (int i = 0; i < 4; i++)
            begin
                // be[3] maps to bytes[0]
                if (be[3-i])
                    mem[waddr].bytes[i] <= wdata.bytes[i];
            end
        end
    end

    // Read word shows up the cycle after the enable
    always_ff @(posedge clk)
    begin
        if (en && !we)
            rdata <= mem[waddr];
    end

    a_be_needs_we: assert property (@(posedge clk) disable iff (rst) (be != 4'b0000) |-> we);

endmodule

//--- lane_translator.sv
`timescale 1ns/1ps

module lane_translator import mem_pkg::*;
(
    input  logic [OP_W-1:0] op,
    input  logic [1:0]      boff,
    input  logic [31:0]     wdata,
    output sram_word_u      sram_wdata,
    output logic [3:0]      be,
    input  sram_word_u      sram_rdata,
    output logic [31:0]     rdata
);

    logic [7:0]  lane;
    logic [15:0] half;

    ////////////////////////////////////////////////////////////////////////////
    // Store side
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        sram_wdata.word = '0;
        be = 4'b0000;
        case (op)
            op_sw:
            begin
                sram_wdata.word = wdata;
                be = 4'b1111;
            end
            op_sh:
            begin
                sram_wdata.word = {2{wdata[15:0]}};
                // Only halfword-aligned offsets get lanes
                case (boff)
                    2'b00: be = 4'b1100;
                    2'b10: be = 4'b0011;
                    default: be = 4'b0000;
                endcase
            end
            op_sb:
            begin
                sram_wdata.word = {4{wdata[7:0]}};
                // Bit 3 of be is byte 0
                be = 4'b1000 >> boff;
            end
            default:
            begin
                sram_wdata.word = '0;
                be = 4'b0000;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Load side
    ////////////////////////////////////////////////////////////////////////////

    assign lane = sram_rdata.bytes[boff];
    assign half = boff[1] ? {sram_rdata.bytes[2], sram_rdata.bytes[3]}
                          : {sram_rdata.bytes[0], sram_rdata.bytes[1]};

    always_comb
    begin
        rdata = '0;
        case (op)
            op_lw: rdata = sram_rdata.word;
            op_lh: if (!boff[0]) rdata = {{16{half[15]}}, half};
            op_lhu: if (!boff[0]) rdata = {16'b0, half};
            op_lb: rdata = {{24{lane[7]}}, lane};
            op_lbu: rdata = {24'b0, lane};
            default: rdata = '0;
        endcase
    end

endmodule

//--- mem_pkg.sv
package mem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Memory geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int SRAM_DEPTH = 256;

    // Word address into the SRAM
    localparam int WADDR_W = 8;

    // Byte address whose low two bits select the lane
    localparam int BADDR_W = 10;

    localparam int OP_W = 6;

    ////////////////////////////////////////////////////////////////////////////
    // MIPS primary opcode values
    ////////////////////////////////////////////////////////////////////////////

    // Loads
    localparam logic [OP_W-1:0] op_lb  = 6'b100000;
    localparam logic [OP_W-1:0] op_lh  = 6'b100001;
    localparam logic [OP_W-1:0] op_lw  = 6'b100011;
    localparam logic [OP_W-1:0] op_lbu = 6'b100100;
    localparam logic [OP_W-1:0] op_lhu = 6'b100101;

    // Stores
    localparam logic [OP_W-1:0] op_sb  = 6'b101000;
    localparam logic [OP_W-1:0] op_sh  = 6'b101001;
    localparam logic [OP_W-1:0] op_sw  = 6'b101011;

    ////////////////////////////////////////////////////////////////////////////
    // SRAM word
    ////////////////////////////////////////////////////////////////////////////

    // Big-endian byte view with bytes[0] in bits 31:24
    typedef union packed {
        logic [31:0]       word;
        logic [0:3][7:0]   bytes;
    } sram_word_u;

endpackage
